// ==== common/vic_timing_pkg.sv ====
`default_nettype none

package vic_timing_pkg;

    // widths of the timing vectors
    localparam int PHASE_W  = 5;
    localparam int XCYCLE_W = 7;
    localparam int LINE_W   = 9;

    // position of the 4x clock within one processor cycle
    // 8 dots of 4 ticks each, so 32 positions
    typedef logic [PHASE_W-1:0] phase_t;

    // last position of a processor cycle
    localparam phase_t PHASE_LAST = phase_t'(31);

    // raster cycle number within a line, up to 65 cycles
    typedef logic [XCYCLE_W-1:0] xcycle_t;

    // raster line number, up to 312 lines
    typedef logic [LINE_W-1:0] line_t;

    // startup hold after lock, in clk_dot4x cycles
    // roughly 150 ms on the board, kept short here
    localparam int RST_HOLD_CYCLES = 64;

    // counts from 0 up to and including RST_HOLD_CYCLES
    typedef logic [$clog2(RST_HOLD_CYCLES+1)-1:0] hold_cnt_t;

    // reset sequencer states
    typedef enum logic [1:0] {
        WAIT_LOCK,
        HOLD,
        RUN
    } seq_state_t;

endpackage : vic_timing_pkg

`default_nettype wire

// ==== common/vic_chip_pkg.sv ====
`default_nettype none

package vic_chip_pkg;

    // totals are expressed in the raster counter types
    import vic_timing_pkg::*;

    // chip model strap
    typedef logic [1:0] chip_t;

    localparam chip_t CHIP6567R8   = chip_t'(0);
    localparam chip_t CHIP6569     = chip_t'(1);
    localparam chip_t CHIP6567R56A = chip_t'(2);
    localparam chip_t CHIP6572     = chip_t'(3);

    // cycles per raster line
    localparam xcycle_t CYCLES_R8   = xcycle_t'(65);
    localparam xcycle_t CYCLES_6569 = xcycle_t'(63);
    localparam xcycle_t CYCLES_R56A = xcycle_t'(64);
    localparam xcycle_t CYCLES_6572 = xcycle_t'(65);

    // raster lines per frame
    localparam line_t LINES_R8   = line_t'(263);
    localparam line_t LINES_6569 = line_t'(312);
    localparam line_t LINES_R56A = line_t'(262);
    localparam line_t LINES_6572 = line_t'(312);

    // cycles per line for a given model
    function automatic xcycle_t cycles_per_line(chip_t c);
        case (c)
            CHIP6567R8:   return CYCLES_R8;
            CHIP6569:     return CYCLES_6569;
            CHIP6567R56A: return CYCLES_R56A;
            default:      return CYCLES_6572;
        endcase
    endfunction

    // lines per frame for a given model
    function automatic line_t lines_per_frame(chip_t c);
        case (c)
            CHIP6567R8:   return LINES_R8;
            CHIP6569:     return LINES_6569;
            CHIP6567R56A: return LINES_R56A;
            default:      return LINES_6572;
        endcase
    endfunction

endpackage : vic_chip_pkg

`default_nettype wire

// ==== clockgen/reset_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

// holds the core in reset until lock plus a startup hold
module reset_sequencer
    import vic_timing_pkg::*;
(
    input  logic clk_dot4x,
    input  logic internal_rst,
    input  logic locked,
    output logic rst
);

    seq_state_t state;
    hold_cnt_t  hold_cnt;

    // bit 0 takes the state decode, bit 1 drives rst
    logic [1:0] rst_sync;

    // lost lock behaves like a fresh power up
    always_ff @(posedge clk_dot4x) begin
        if (internal_rst || !locked) begin
            state    <= WAIT_LOCK;
            hold_cnt <= '0;
        end else begin
            case (state)
                // locked is high here, start the hold
                WAIT_LOCK: begin
                    state    <= HOLD;
                    hold_cnt <= '0;
                end
                // count out the full hold before running
                HOLD: begin
                    if (hold_cnt == hold_cnt_t'(RST_HOLD_CYCLES)) begin
                        state <= RUN;
                    end else begin
                        hold_cnt <= hold_cnt + hold_cnt_t'(1);
                    end
                end
                RUN: begin
                    state <= RUN;
                end
                default: begin
                    state <= WAIT_LOCK;
                end
            endcase
        end
    end

    // assert straight away, release only through both flops
    always_ff @(posedge clk_dot4x) begin
        if (internal_rst || !locked) begin
            rst_sync <= 2'b11;
        end else begin
            rst_sync <= {rst_sync[0], state != RUN};
        end
    end

    assign rst = rst_sync[1];

endmodule : reset_sequencer

`default_nettype wire

// ==== clockgen/dot_phase_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

// splits the 4x dot clock into dot and processor timing
module dot_phase_gen
    import vic_timing_pkg::*;
(
    input  logic clk_dot4x,
    input  logic internal_rst,
    output logic dot_en,
    output logic phi,
    output logic cycle_end
);

    // current position within the processor cycle
    phase_t phase;
    phase_t phase_next;

    // wraps from PHASE_LAST back to 0 on its own
    assign phase_next = phase + phase_t'(1);

    // free running, the dot clock has to tick during the startup hold
    always_ff @(posedge clk_dot4x) begin
        if (internal_rst) begin
            phase     <= '0;
            dot_en    <= 1'b0;
            phi       <= 1'b0;
            cycle_end <= 1'b0;
        end else begin
            phase <= phase_next;

            // decodes use the next position so outputs line up with phase

            // one dot every four ticks
            dot_en <= (phase_next[1:0] == 2'b00);

            // phi is the upper half, positions 16 to 31
            phi <= phase_next[PHASE_W-1];

            // last tick of the processor cycle
            cycle_end <= (phase_next == PHASE_LAST);
        end
    end

endmodule : dot_phase_gen

`default_nettype wire

// ==== verilog/raster_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

// raster cycle and line counters for the selected chip model
module raster_timing
    import vic_chip_pkg::*;
    import vic_timing_pkg::*;
(
    input  logic    clk_dot4x,
    input  logic    rst,
    input  logic    cycle_end,
    input  chip_t   chip,
    output xcycle_t cycle_num,
    output line_t   raster_line,
    output logic    line_start,
    output logic    frame_start
);

    // model strap as sampled during reset
    chip_t chip_q;

    // totals of the latched model
    xcycle_t cycles_total;
    line_t   lines_total;

    // last valid counter values
    xcycle_t last_cycle;
    line_t   last_line;

    assign cycles_total = cycles_per_line(chip_q);
    assign lines_total  = lines_per_frame(chip_q);

    assign last_cycle = cycles_total - xcycle_t'(1);
    assign last_line  = lines_total - line_t'(1);

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            // strap follows the pin for as long as reset holds
            chip_q      <= chip;
            cycle_num   <= '0;
            raster_line <= '0;
            line_start  <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            // strobes last one clock
            line_start  <= 1'b0;
            frame_start <= 1'b0;

            if (cycle_end) begin
                if (cycle_num == last_cycle) begin
                    // end of line, strobe lands with cycle 0
                    cycle_num  <= '0;
                    line_start <= 1'b1;

                    if (raster_line == last_line) begin
                        // end of frame, back to line 0
                        raster_line <= '0;
                        frame_start <= 1'b1;
                    end else begin
                        raster_line <= raster_line + line_t'(1);
                    end
                end else begin
                    cycle_num <= cycle_num + xcycle_t'(1);
                end
            end
        end
    end

endmodule : raster_timing

`default_nettype wire

// ==== verilog/vic_timing_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// clock and timing front end
module vic_timing_top
    import vic_chip_pkg::*;
    import vic_timing_pkg::*;
(
    input  logic    clk_dot4x,
    input  logic    internal_rst,
    input  logic    locked,
    input  chip_t   chip,
    output logic    rst,
    output logic    phi,
    output logic    dot_en,
    output xcycle_t cycle_num,
    output line_t   raster_line,
    output logic    line_start,
    output logic    frame_start
);

    // end of each processor cycle, feeds the raster counter
    logic cycle_end;

    // core reset from lock and startup hold
    reset_sequencer u_reset_sequencer (
        .clk_dot4x   (clk_dot4x),
        .internal_rst(internal_rst),
        .locked      (locked),
        .rst         (rst)
    );

    // runs on board reset only, so phases exist during the hold
    dot_phase_gen u_dot_phase_gen (
        .clk_dot4x   (clk_dot4x),
        .internal_rst(internal_rst),
        .dot_en      (dot_en),
        .phi         (phi),
        .cycle_end   (cycle_end)
    );

    raster_timing u_raster_timing (
        .clk_dot4x  (clk_dot4x),
        .rst        (rst),
        .cycle_end  (cycle_end),
        .chip       (chip),
        .cycle_num  (cycle_num),
        .raster_line(raster_line),
        .line_start (line_start),
        .frame_start(frame_start)
    );

endmodule : vic_timing_top

`default_nettype wire

// ==== sim/vic_timing_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

// strobe and counter range checks, bound into raster_timing
module vic_timing_asserts
    import vic_timing_pkg::*;
(
    input logic    clk_dot4x,
    input logic    rst,
    input logic    cycle_end,
    input logic    line_start,
    input logic    frame_start,
    input xcycle_t cycle_num,
    input line_t   raster_line,
    input xcycle_t cycles_total,
    input line_t   lines_total
);

    // line_start is registered from the cycle_end strobe of dot_phase_gen
    a_line_needs_cycle_end: assert property (
        @(posedge clk_dot4x) disable iff (rst)
        line_start |-> $past(cycle_end)
    ) else $error("line_start without a cycle_end before it");

    // a new frame always opens a new line
    a_frame_implies_line: assert property (
        @(posedge clk_dot4x) disable iff (rst)
        frame_start |-> line_start
    ) else $error("frame_start without line_start");

    // counters stay inside the totals of the latched model
    a_counters_in_range: assert property (
        @(posedge clk_dot4x) disable iff (rst)
        (cycle_num < cycles_total) && (raster_line < lines_total)
    ) else $error("raster counter beyond the model totals");

endmodule : vic_timing_asserts

bind raster_timing vic_timing_asserts u_asserts (
    .clk_dot4x   (clk_dot4x),
    .rst         (rst),
    .cycle_end   (cycle_end),
    .line_start  (line_start),
    .frame_start (frame_start),
    .cycle_num   (cycle_num),
    .raster_line (raster_line),
    .cycles_total(cycles_total),
    .lines_total (lines_total)
);

`default_nettype wire

// ==== sim/vic_timing_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module vic_timing_tb
    import vic_chip_pkg::*;
    import vic_timing_pkg::*;
();

    localparam int CLK_PERIOD      = 20;
    localparam int NUM_ROWS        = 4;
    localparam int TICKS_PER_CYCLE = 32;
    localparam int RELEASE_TIMEOUT = 200;
    localparam int LINE_TIMEOUT    = 5000;
    localparam int FRAME_TIMEOUT   = 700000;

    logic    clk_dot4x;
    logic    internal_rst;
    logic    locked;
    chip_t   chip;
    logic    rst;
    logic    phi;
    logic    dot_en;
    xcycle_t cycle_num;
    line_t   raster_line;
    logic    line_start;
    logic    frame_start;

    // one row per model, expected totals written out by hand
    chip_t tbl_chip   [NUM_ROWS];
    int    tbl_cycles [NUM_ROWS];
    int    tbl_lines  [NUM_ROWS];

    vic_timing_top dut (
        .clk_dot4x   (clk_dot4x),
        .internal_rst(internal_rst),
        .locked      (locked),
        .chip        (chip),
        .rst         (rst),
        .phi         (phi),
        .dot_en      (dot_en),
        .cycle_num   (cycle_num),
        .raster_line (raster_line),
        .line_start  (line_start),
        .frame_start (frame_start)
    );

    initial begin
        clk_dot4x = 1'b0;
        forever #(CLK_PERIOD / 2) clk_dot4x = ~clk_dot4x;
    end

    task automatic check_value(input string what, input int actual, input int expected);
        if (actual != expected) begin
            $display("ERR at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timed out while waiting for %s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "wait timed out");
    endtask

    // counts clocks up to and including the next line_start
    task automatic wait_for_line(input string what, output int gap);
        gap = 0;
        do begin
            @(negedge clk_dot4x);
            gap++;
            if (gap > LINE_TIMEOUT) begin
                report_timeout(what);
            end
        end while (!line_start);
    endtask

    // dot_en every fourth tick, phi high for half of each processor cycle
    task automatic check_phases();
        int   tries;
        int   pos;
        int   phi_count;
        logic phi_prev;
        tries = 0;
        @(negedge clk_dot4x);
        while (!dot_en) begin
            if (tries == 8) begin
                report_timeout("the first dot enable");
            end
            tries++;
            @(negedge clk_dot4x);
        end
        phi_prev  = phi;
        phi_count = 0;
        for (pos = 0; pos < 64; pos++) begin
            if (pos > 0) begin
                @(negedge clk_dot4x);
            end
            check_value("dot_en", int'(dot_en), (pos % 4 == 0) ? 1 : 0);
            // phi only toggles on a dot boundary
            if (phi != phi_prev) begin
                check_value("dot_en at a phi edge", int'(dot_en), 1);
            end
            phi_prev = phi;
            if (phi) begin
                phi_count++;
            end
            if (pos % 32 == 31) begin
                check_value("phi high clocks per processor cycle", phi_count, 16);
                phi_count = 0;
            end
        end
    endtask

    // lock loss raises rst next cycle, new strap goes in while reset holds
    task automatic lose_lock(input chip_t new_chip);
        @(posedge clk_dot4x);
        locked <= 1'b0;
        @(posedge clk_dot4x);
        @(negedge clk_dot4x);
        check_value("rst after lock loss", int'(rst), 1);
        @(posedge clk_dot4x);
        chip <= new_chip;
        @(negedge clk_dot4x);
        check_value("cycle_num in reset", int'(cycle_num), 0);
        check_value("raster_line in reset", int'(raster_line), 0);
    endtask

    // relock and time the release of rst
    task automatic relock();
        int edges;
        logic released;
        repeat (4) @(posedge clk_dot4x);
        locked <= 1'b1;
        // first edge that samples locked high
        @(posedge clk_dot4x);
        edges    = 0;
        released = 1'b0;
        while (!released) begin
            @(posedge clk_dot4x);
            edges++;
            @(negedge clk_dot4x);
            check_value("line_start before release", int'(line_start), 0);
            check_value("frame_start before release", int'(frame_start), 0);
            if (!rst) begin
                released = 1'b1;
            end else if (edges > RELEASE_TIMEOUT) begin
                report_timeout("rst to fall after lock");
            end
        end
        check_value("clocks from lock to release", edges, RST_HOLD_CYCLES + 3);
    endtask

    task automatic measure_lines(input int row, input int count);
        int gap;
        int n;
        wait_for_line("a line start after release", gap);
        check_value("cycle_num at line start", int'(cycle_num), 0);
        for (n = 0; n < count; n++) begin
            wait_for_line("the next line start", gap);
            check_value("line length in clocks", gap, TICKS_PER_CYCLE * tbl_cycles[row]);
            check_value("cycle_num at line start", int'(cycle_num), 0);
        end
    endtask

    // counts line starts from one frame start to the next
    task automatic measure_frame(input int row);
        int waited;
        int gap;
        int lines;
        waited = 0;
        do begin
            @(negedge clk_dot4x);
            waited++;
            if (waited > FRAME_TIMEOUT) begin
                report_timeout("a frame start");
            end
        end while (!frame_start);
        check_value("raster_line at frame start", int'(raster_line), 0);
        lines = 0;
        do begin
            wait_for_line("a line start within the frame", gap);
            check_value("line length in clocks", gap, TICKS_PER_CYCLE * tbl_cycles[row]);
            check_value("cycle_num at line start", int'(cycle_num), 0);
            lines++;
            // too many lines fails here rather than running on
            if (lines > tbl_lines[row]) begin
                check_value("lines per frame", lines, tbl_lines[row]);
            end
        end while (!frame_start);
        check_value("lines per frame", lines, tbl_lines[row]);
        check_value("raster_line at frame start", int'(raster_line), 0);
    endtask

    initial begin
        int row;
        // 6567R56A, 6567R8, 6569, 6572
        tbl_chip[0]   = CHIP6567R56A;
        tbl_cycles[0] = 64;
        tbl_lines[0]  = 262;
        tbl_chip[1]   = CHIP6567R8;
        tbl_cycles[1] = 65;
        tbl_lines[1]  = 263;
        tbl_chip[2]   = CHIP6569;
        tbl_cycles[2] = 63;
        tbl_lines[2]  = 312;
        tbl_chip[3]   = CHIP6572;
        tbl_cycles[3] = 65;
        tbl_lines[3]  = 312;

        internal_rst = 1'b1;
        locked       = 1'b0;
        chip         = tbl_chip[0];

        repeat (5) @(posedge clk_dot4x);
        internal_rst <= 1'b0;

        // phases run free while the core is still held
        check_phases();

        for (row = 0; row < NUM_ROWS; row++) begin
            $display("model row %0d: %0d cycles, %0d lines", row, tbl_cycles[row],
                     tbl_lines[row]);
            if (row > 0) begin
                // move a few processor cycles into the line
                repeat (3 * TICKS_PER_CYCLE + 5) @(negedge clk_dot4x);
                check_value("raster mid frame before lock loss", int'(raster_line != '0), 1);
                check_value("cycle_num mid line before lock loss", int'(cycle_num != '0), 1);
            end
            lose_lock(tbl_chip[row]);
            relock();
            // first lines show the new model is in effect
            measure_lines(row, 2);
            measure_frame(row);
            // leave the raster mid frame for the next lock loss
            measure_lines(row, 3);
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule : vic_timing_tb

`default_nettype wire

// ==== filelist.f ====
common/vic_timing_pkg.sv
common/vic_chip_pkg.sv
clockgen/reset_sequencer.sv
clockgen/dot_phase_gen.sv
verilog/raster_timing.sv
verilog/vic_timing_top.sv
sim/vic_timing_asserts.sv
sim/vic_timing_tb.sv

// ==== Makefile ====
TOOL      := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := vic_timing_tb
FILELIST  := filelist.f
BUILD_DIR := obj_dir
BIN       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
